/* bench/tb_z3_ram_card.sv */
// single-master bench at 50 MHz; memory checks only cover words written first, RAM has no reset
`default_nettype none

`include "z3_defs.svh"

module tb_z3_ram_card
	import z3_bus_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_WORDS   = 16;
	localparam int N_RAND    = 32;
	// pre-config, id reads, config write, cfg after, space misses, timeout, zorro II
	localparam int N_TRANS   = 14 + N_WORDS + N_RAND + N_WORDS;
	localparam int RST_CYC   = 10;
	localparam int WD_CYC    = N_TRANS * 40 + RST_CYC;
	localparam int ACK_WAIT  = 16;
	localparam logic [7:0] BASE = 8'h40;

	logic        clk = 1'b0;
	logic        nIORST;
	z3_bus_in_t  bus_in;
	z3_bus_out_t bus_o;
	logic        cfgin_n;
	logic        sense;
	logic        cfgout_n;

	int          chk_cnt = 0;
	int          err_cnt = 0;
	int          sva_err = 0;
	logic [31:0] rng = 32'd13;
	// expected memory contents, per test word
	logic [31:0] shadow [N_WORDS];

	z3_ram_card dut_i (
		.clk        (clk),
		.nIORST     (nIORST),
		.bus_i      (bus_in),
		.cfgin_n_i  (cfgin_n),
		.sense_z3_i (sense),
		.bus_o      (bus_o),
		.cfgout_n_o (cfgout_n)
	);

	// 20 ns period
	always #10 clk = ~clk;

	// ----------------------------------------
	// bus protocol assertions
	// ----------------------------------------
	// everything quiet while in reset
	assert property (@(posedge clk) !nIORST |->
		bus_o.slave_n && bus_o.dtack_n && !bus_o.data_oe && cfgout_n)
	else begin
		sva_err++;
		$display("card outputs not idle during reset at %0t", $time);
	end

	// data enable only while acknowledging
	assert property (@(posedge clk) disable iff (!nIORST) bus_o.data_oe |-> !bus_o.dtack_n)
	else begin
		sva_err++;
		$display("data output enable without acknowledge at %0t", $time);
	end

	// acknowledge only inside a slave cycle
	assert property (@(posedge clk) disable iff (!nIORST) !bus_o.dtack_n |-> !bus_o.slave_n)
	else begin
		sva_err++;
		$display("acknowledge asserted without slave line at %0t", $time);
	end

	// zorro II backplane, card silent and chain passed through
	assert property (@(posedge clk) disable iff (!nIORST) !sense |->
		bus_o.slave_n && bus_o.dtack_n && (cfgout_n == cfgin_n))
	else begin
		sva_err++;
		$display("card active or chain broken on zorro II backplane at %0t", $time);
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic z3_bus_in_t idle_bus();
		z3_bus_in_t b;
		b = '0;
		b.fcs_n = 1'b1;
		b.read  = 1'b1;
		b.ds_n  = 4'hF;
		return b;
	endfunction

	function automatic z3_addr_u cfg_addr(input logic [8:0] ofs);
		z3_addr_u a;
		a = '0;
		a.cfg.upper   = `Z3_CFG_SPACE;
		a.cfg.reg_ofs = ofs[8:2];
		return a;
	endfunction

	function automatic z3_addr_u card_addr(input logic [7:0] base, input logic [7:0] idx);
		z3_addr_u a;
		a = '0;
		a.card.base = base;
		a.card.word = {14'd0, idx};
		return a;
	endfunction

	// id nibble on top, all other bits one
	function automatic logic [31:0] id_word(input logic [8:0] ofs);
		logic [3:0] nib;
		case (ofs)
			9'h000:  nib = `Z3_CFG_TYPE_HI;
			9'h004:  nib = `Z3_CFG_TYPE_LO;
			9'h008:  nib = `Z3_CFG_PROD_HI;
			9'h00C:  nib = `Z3_CFG_PROD_LO;
			default: nib = 4'hF;
		endcase
		return {nib, 28'hFFF_FFFF};
	endfunction

	// spread test words over the memory, 37 odd so all distinct
	function automatic logic [7:0] word_idx(input int k);
		return 8'(k * 37 + 5);
	endfunction

	// one contiguous run of byte lanes
	function automatic logic [3:0] contig_be(input logic [31:0] r);
		case (r % 32'd10)
			32'd0:   return 4'b0001;
			32'd1:   return 4'b0010;
			32'd2:   return 4'b0100;
			32'd3:   return 4'b1000;
			32'd4:   return 4'b0011;
			32'd5:   return 4'b0110;
			32'd6:   return 4'b1100;
			32'd7:   return 4'b0111;
			32'd8:   return 4'b1110;
			default: return 4'b1111;
		endcase
	endfunction

	function automatic logic [31:0] lane_merge(input logic [31:0] old,
			input logic [31:0] wdata, input logic [3:0] be);
		logic [31:0] r;
		r = old;
		for (int b = 0; b < 4; b++) begin
			if (be[b])
				r[8*b +: 8] = wdata[8*b +: 8];
		end
		return r;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		chk_cnt++;
		assert (act == exp)
		else begin
			err_cnt++;
			$display("** Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		chk_cnt++;
		assert (act == exp)
		else begin
			err_cnt++;
			$display("** Error %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// ----------------------------------------
	// master side of a bus cycle
	// ----------------------------------------
	// address phase, then data phase one clk later
	task automatic start_cycle(input z3_addr_u a, input logic [1:0] fc, input logic rd,
			input logic [3:0] be, input logic [31:0] wdata);
		@(posedge clk);
		bus_in.fcs_n <= 1'b0;
		bus_in.addr  <= a;
		bus_in.fc    <= fc;
		bus_in.read  <= rd;
		@(posedge clk);
		bus_in.doe   <= 1'b1;
		bus_in.ds_n  <= ~be;
		bus_in.wdata <= wdata;
	endtask

	// returns on the falling edge where dtack is seen low
	task automatic wait_ack(input string name, output bit ok);
		int n;
		n = 0;
		ok = 1'b1;
		@(negedge clk);
		while (bus_o.dtack_n && n < ACK_WAIT) begin
			n++;
			@(negedge clk);
		end
		if (bus_o.dtack_n) begin
			err_cnt++;
			ok = 1'b0;
			$display("%s: no acknowledge within %0d cycles", name, ACK_WAIT);
		end
	endtask

	// strobe up, then slave and dtack gone one clk after the card sees it
	task automatic end_cycle(input string name);
		@(posedge clk);
		bus_in <= idle_bus();
		@(posedge clk);
		@(negedge clk);
		check_bit({name, " slave release"}, 1'b1, bus_o.slave_n);
		check_bit({name, " dtack release"}, 1'b1, bus_o.dtack_n);
	endtask

	task automatic read_word(input string name, input z3_addr_u a, output logic [31:0] data);
		bit ok;
		start_cycle(a, `Z3_FC_DATA, 1'b1, 4'hF, 32'h0);
		wait_ack(name, ok);
		data = bus_o.rdata;
		if (ok) begin
			check_bit({name, " slave"}, 1'b0, bus_o.slave_n);
			check_bit({name, " data enable"}, 1'b1, bus_o.data_oe);
		end
		end_cycle(name);
	endtask

	task automatic write_word(input string name, input z3_addr_u a, input logic [3:0] be,
			input logic [31:0] wdata);
		bit ok;
		start_cycle(a, `Z3_FC_DATA, 1'b0, be, wdata);
		wait_ack(name, ok);
		if (ok) begin
			check_bit({name, " slave"}, 1'b0, bus_o.slave_n);
			check_bit({name, " data enable"}, 1'b0, bus_o.data_oe);
		end
		end_cycle(name);
	endtask

	// cycle the card must ignore
	task automatic expect_silent(input string name, input z3_addr_u a, input logic [1:0] fc);
		start_cycle(a, fc, 1'b1, 4'hF, 32'h0);
		repeat (8) begin
			@(negedge clk);
			check_bit({name, " slave"}, 1'b1, bus_o.slave_n);
			check_bit({name, " dtack"}, 1'b1, bus_o.dtack_n);
		end
		end_cycle(name);
	endtask

	// ----------------------------------------
	// watchdog
	// ----------------------------------------
	initial begin
		repeat (WD_CYC) @(posedge clk);
		$display("watchdog expired after %0d cycles, tests did not finish", WD_CYC);
		$display("Result: FAILED");
		$finish;
	end

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		logic [31:0] data;
		logic [3:0]  be;
		logic [8:0]  ofs;
		int          k;
		int          cnt;
		bit          ok;

		bus_in  <= idle_bus();
		cfgin_n <= 1'b0;
		sense   <= 1'b1;
		nIORST  <= 1'b0;
		repeat (RST_CYC) @(posedge clk);
		nIORST <= 1'b1;

		// after reset
		@(negedge clk);
		check_bit("reset slave", 1'b1, bus_o.slave_n);
		check_bit("reset dtack", 1'b1, bus_o.dtack_n);
		check_bit("reset data enable", 1'b0, bus_o.data_oe);
		check_bit("reset chain out", 1'b1, cfgout_n);
		expect_silent("unconfigured card", card_addr(BASE, 8'h00), `Z3_FC_DATA);

		// identification table, 0x10 is unlisted
		for (int i = 0; i < 5; i++) begin
			ofs = 9'(i * 4);
			read_word($sformatf("config read %03h", ofs), cfg_addr(ofs), data);
			check_val($sformatf("config read %03h", ofs), id_word(ofs), data);
		end

		// base write, card moves into memory space
		write_word("config base write", cfg_addr(9'h044), 4'hF, {BASE, 24'h0});
		@(negedge clk);
		check_bit("chain out after base", 1'b0, cfgout_n);
		expect_silent("config after base", cfg_addr(9'h000), `Z3_FC_DATA);

		// full-word fill of the test words
		for (int i = 0; i < N_WORDS; i++) begin
			rng = xorshift32(rng);
			shadow[i] = rng;
			write_word($sformatf("fill %0d", i), card_addr(BASE, word_idx(i)), 4'hF, rng);
		end

		// partial writes, random lanes
		for (int i = 0; i < N_RAND; i++) begin
			rng = xorshift32(rng);
			// N_WORDS is 16
			k = int'(rng[3:0]);
			rng = xorshift32(rng);
			be = contig_be(rng);
			rng = xorshift32(rng);
			write_word($sformatf("lane write %0d", i), card_addr(BASE, word_idx(k)), be, rng);
			shadow[k] = lane_merge(shadow[k], rng, be);
		end

		for (int i = 0; i < N_WORDS; i++) begin
			read_word($sformatf("readback %0d", i), card_addr(BASE, word_idx(i)), data);
			check_val($sformatf("readback %0d", i), shadow[i], data);
		end

		// wrong memory space and wrong base
		expect_silent("fc 00", card_addr(BASE, word_idx(0)), 2'b00);
		expect_silent("fc 11", card_addr(BASE, word_idx(0)), 2'b11);
		expect_silent("other base", card_addr(BASE + 8'h01, word_idx(0)), `Z3_FC_DATA);

		// strobe held after dtack, count the acknowledge clks
		start_cycle(card_addr(BASE, word_idx(1)), `Z3_FC_DATA, 1'b1, 4'hF, 32'h0);
		wait_ack("timeout", ok);
		check_val("timeout data", shadow[1], bus_o.rdata);
		cnt = 0;
		while (!bus_o.dtack_n && cnt < `Z3_DTACK_TIMEOUT + 10) begin
			cnt++;
			@(negedge clk);
		end
		check_val("timeout length", 32'(`Z3_DTACK_TIMEOUT), 32'(cnt));
		repeat (3) begin
			@(negedge clk);
			check_bit("timeout dtack held off", 1'b1, bus_o.dtack_n);
			check_bit("timeout data enable", 1'b0, bus_o.data_oe);
		end
		end_cycle("timeout");

		// zorro II backplane
		@(posedge clk);
		sense <= 1'b0;
		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
			cfgin_n <= i[0];
			@(negedge clk);
			check_bit("zorro II chain", cfgin_n, cfgout_n);
		end
		expect_silent("zorro II config", cfg_addr(9'h000), `Z3_FC_DATA);
		expect_silent("zorro II card", card_addr(BASE, word_idx(2)), `Z3_FC_DATA);

		$display("checks %0d, value errors %0d, assertion errors %0d",
			chk_cnt, err_cnt, sva_err);
		if (err_cnt == 0 && sva_err == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* design/autocfg_regs.sv */
// config space reads return one nibble on d31:28, rest ones; base and shut-up are write-only
`default_nettype none

`include "z3_defs.svh"

module autocfg_regs
	import card_pkg::*;
(
	input  logic       clk,
	input  logic       nIORST,
	input  card_req_t  req_i,
	input  logic       cfgin_n_i,
	input  logic       sense_z3_i,
	output card_rsp_t  rsp_o,
	output logic [7:0] base_o,
	output logic       configured_o,
	output logic       shutup_o,
	output logic       cfgout_n_o
);

	logic [8:0]  ofs;
	logic [3:0]  nib;
	logic        ack_q;
	logic [31:0] rdata_q;
	logic [7:0]  base_q;
	logic        configured_q;
	logic        shutup_q;

	// register word back to a byte offset
	assign ofs = {req_i.idx[6:0], 2'b00};

	// ----------------------------------------
	// identification table
	// ----------------------------------------
	always_comb begin
		case (ofs)
			`Z3_CFG_TYPE_HI_OFS: nib = `Z3_CFG_TYPE_HI;
			`Z3_CFG_TYPE_LO_OFS: nib = `Z3_CFG_TYPE_LO;
			`Z3_CFG_PROD_HI_OFS: nib = `Z3_CFG_PROD_HI;
			`Z3_CFG_PROD_LO_OFS: nib = `Z3_CFG_PROD_LO;
			// anything else reads as all ones
			default: nib = 4'hF;
		endcase
	end

	// ----------------------------------------
	// writes and acknowledge
	// ----------------------------------------
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			ack_q        <= 1'b0;
			base_q       <= 8'h00;
			configured_q <= 1'b0;
			shutup_q     <= 1'b0;
		end else begin
			ack_q <= req_i.stb;
			if (req_i.stb && req_i.we) begin
				// base byte sits on d31:24
				if (ofs == `Z3_CFG_BASE_OFS) begin
					base_q       <= req_i.wdata[31:24];
					configured_q <= 1'b1;
				end
				if (ofs == `Z3_CFG_SHUTUP_OFS)
					shutup_q <= 1'b1;
			end
		end
	end

	// read word, captured with the strobe
	always_ff @(posedge clk) begin
		if (req_i.stb)
			rdata_q <= {nib, 28'hFFF_FFFF};
	end

	assign rsp_o = '{ack: ack_q, rdata: rdata_q};

	assign base_o       = base_q;
	assign configured_o = configured_q;
	assign shutup_o     = shutup_q;

	// chain passes through untouched on a zorro II backplane
	assign cfgout_n_o = sense_z3_i ? ~(configured_q | shutup_q) : cfgin_n_i;

endmodule

`default_nettype wire

/* design/card_pkg.sv */
// card-side target handshake; one word per request, acknowledge exactly one clk after strobe
`default_nettype none

`include "z3_defs.svh"

package card_pkg;

	// ----------------------------------------
	// index width from memory depth
	// ----------------------------------------
	localparam int unsigned CARD_IDX_W = $clog2(`CARD_RAM_WORDS);

	// word index, also wide enough for a config register word
	typedef logic [CARD_IDX_W-1:0] card_idx_t;

	// ----------------------------------------
	// controller to target
	// ----------------------------------------
	// stb is a single-clk pulse
	typedef struct packed {
		logic        stb;
		logic        we;
		logic [3:0]  be;		// be[3] is d31:24
		card_idx_t   idx;
		logic [31:0] wdata;
	} card_req_t;

	// ----------------------------------------
	// target to controller
	// ----------------------------------------
	// rdata valid while ack is high
	typedef struct packed {
		logic        ack;
		logic [31:0] rdata;
	} card_rsp_t;

endpackage

`default_nettype wire

/* design/card_ram.sv */
// single-port word memory, one request at a time; write returns the old word on rdata
`default_nettype none

`include "z3_defs.svh"

module card_ram
	import card_pkg::*;
(
	input  logic      clk,
	input  logic      nIORST,
	input  card_req_t req_i,
	output card_rsp_t rsp_o
);

	// ----------------------------------------
	// storage
	// ----------------------------------------
	logic [31:0] mem [`CARD_RAM_WORDS];
	logic [31:0] rdata_q;
	logic        ack_q;

	// lane b holds d(8b+7):d(8b)
	always_ff @(posedge clk) begin
		if (req_i.stb) begin
			if (req_i.we) begin
				for (int b = 0; b < 4; b++) begin
					if (req_i.be[b])
						mem[req_i.idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
				end
			end
			// read port sees the word before this write
			rdata_q <= mem[req_i.idx];
		end
	end

	// ----------------------------------------
	// acknowledge
	// ----------------------------------------
	// one clk behind the strobe, with the read word
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST)
			ack_q <= 1'b0;
		else
			ack_q <= req_i.stb;
	end

	assign rsp_o = '{ack: ack_q, rdata: rdata_q};

endmodule

`default_nettype wire

/* design/z3_addr_decode.sv */
// address is taken from the sample at the strobe fall; master must hold it one clk past that edge
`default_nettype none

`include "z3_defs.svh"

module z3_addr_decode
	import z3_bus_pkg::*;
(
	input  logic       clk,
	input  logic       nIORST,
	input  z3_bus_in_t bus_i,
	input  logic       cfgin_n_i,
	input  logic       sense_z3_i,
	input  logic [7:0] base_i,
	input  logic       configured_i,
	input  logic       shutup_i,
	output z3_addr_u   addr_o,
	output logic       cfg_hit_o,
	output logic       card_hit_o,
	output logic       read_o,
	output logic       cyc_o,
	output logic       slave_n_o
);

	// strobe history
	logic       fcs_q;
	logic       fcs_qq;
	// bus sample taken with the strobe
	z3_addr_u   addr_s;
	logic       read_s;
	logic [1:0] fc_s;
	logic       fall_seen;
	logic       fc_ok;
	logic       cfg_match;
	logic       card_match;
	// held for the whole cycle
	z3_addr_u   addr_q;
	logic       read_q;
	logic       cyc_q;
	logic       cfg_hit_q;
	logic       card_hit_q;

	// ----------------------------------------
	// sampling
	// ----------------------------------------
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			fcs_q  <= 1'b1;
			fcs_qq <= 1'b1;
		end else begin
			fcs_q  <= bus_i.fcs_n;
			fcs_qq <= fcs_q;
		end
	end

	always_ff @(posedge clk) begin
		addr_s <= bus_i.addr;
		read_s <= bus_i.read;
		fc_s   <= bus_i.fc;
	end

	// high for one clk after the edge that first saw the strobe low
	assign fall_seen = ~fcs_q & fcs_qq;

	// ----------------------------------------
	// space match
	// ----------------------------------------
	// user/supervisor data or program only
	assign fc_ok = (fc_s == `Z3_FC_DATA) || (fc_s == `Z3_FC_PROG);

	// unconfigured card, its turn in the chain
	assign cfg_match = (addr_s.cfg.upper == `Z3_CFG_SPACE) & ~cfgin_n_i &
		~configured_i & ~shutup_i & sense_z3_i;

	assign card_match = configured_i & (addr_s.card.base == base_i) & sense_z3_i;

	// ----------------------------------------
	// cycle hold
	// ----------------------------------------
	// hits frozen at the latch edge, so a base write mid-cycle keeps its slave line
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			cyc_q      <= 1'b0;
			cfg_hit_q  <= 1'b0;
			card_hit_q <= 1'b0;
		end else if (bus_i.fcs_n) begin
			cyc_q      <= 1'b0;
			cfg_hit_q  <= 1'b0;
			card_hit_q <= 1'b0;
		end else if (fall_seen) begin
			cyc_q      <= 1'b1;
			cfg_hit_q  <= cfg_match & fc_ok;
			card_hit_q <= card_match & fc_ok;
		end
	end

	always_ff @(posedge clk) begin
		if (fall_seen) begin
			addr_q <= addr_s;
			read_q <= read_s;
		end
	end

	assign addr_o     = addr_q;
	assign read_o     = read_q;
	assign cyc_o      = cyc_q;
	assign cfg_hit_o  = cfg_hit_q;
	assign card_hit_o = card_hit_q;

	// hits are already cleared once the strobe is back up
	assign slave_n_o = ~(cyc_q & (cfg_hit_q | card_hit_q));

endmodule

`default_nettype wire

/* design/z3_bus_pkg.sv */
// bus-side types only; data bus is split into in/out/enable, no multiple-transfer signals
`default_nettype none

package z3_bus_pkg;

	// ----------------------------------------
	// latched address, two readings
	// ----------------------------------------
	// configuration space view
	typedef struct packed {
		logic [15:0] upper;		// addr 31:16
		logic [6:0]  rsvd;		// addr 15:9, ignored
		logic [6:0]  reg_ofs;	// addr 8:2, register word
	} z3_cfg_view_t;

	// card memory view
	typedef struct packed {
		logic [7:0]  base;		// addr 31:24, slot byte
		logic [21:0] word;		// addr 23:2
	} z3_card_view_t;

	// same 30 address bits, decoded either way
	typedef union packed {
		z3_cfg_view_t  cfg;
		z3_card_view_t card;
	} z3_addr_u;

	// ----------------------------------------
	// bus pins
	// ----------------------------------------
	// driven by the bus master
	typedef struct packed {
		logic        fcs_n;		// full cycle strobe
		logic        doe;		// data output enable
		logic        read;
		logic [3:0]  ds_n;		// ds_n[3] strobes d31:24
		logic [1:0]  fc;		// memory space
		z3_addr_u    addr;		// a31:a2
		logic [31:0] wdata;
	} z3_bus_in_t;

	// driven by the card
	typedef struct packed {
		logic        slave_n;
		logic        dtack_n;
		logic [31:0] rdata;
		logic        data_oe;	// card owns the data bus
	} z3_bus_out_t;

	// cycle controller states
	typedef enum logic [2:0] {
		ZS_IDLE,
		ZS_MATCH,
		ZS_DATA,
		ZS_REQ,
		ZS_WAIT_ACK,
		ZS_DTACK,
		ZS_ERR
	} z3_state_e;

endpackage

`default_nettype wire

/* design/z3_cycle_ctrl.sv */
// single-word cycles only; a stuck cycle drops dtack and the data enable but raises no bus error
`default_nettype none

`include "z3_defs.svh"

module z3_cycle_ctrl
	import z3_bus_pkg::*;
	import card_pkg::*;
(
	input  logic        clk,
	input  logic        nIORST,
	input  z3_bus_in_t  bus_i,
	input  z3_addr_u    addr_i,
	input  logic        cfg_hit_i,
	input  logic        card_hit_i,
	input  logic        read_i,
	input  logic        cyc_i,
	input  card_rsp_t   cfg_rsp_i,
	input  card_rsp_t   ram_rsp_i,
	output card_req_t   cfg_req_o,
	output card_req_t   ram_req_o,
	output logic        dtack_n_o,
	output logic [31:0] rdata_o,
	output logic        data_oe_o
);

	localparam int unsigned TMO_W = $clog2(`Z3_DTACK_TIMEOUT + 1);

	z3_state_e        state;
	z3_state_e        next;
	logic             doe_q;
	logic [3:0]       ds_n_q;
	logic [TMO_W-1:0] tmo_cnt;
	logic             tmo_hit;
	logic             hit;
	card_rsp_t        sel_rsp;
	card_req_t        req_q;
	logic [31:0]      rdata_q;

	// data phase strobes, sampled
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			doe_q  <= 1'b0;
			ds_n_q <= 4'hF;
		end else begin
			doe_q  <= bus_i.doe;
			ds_n_q <= bus_i.ds_n;
		end
	end

	assign hit = cfg_hit_i | card_hit_i;
	// hits are exclusive since config space closes once configured
	assign sel_rsp = cfg_hit_i ? cfg_rsp_i : ram_rsp_i;

	// ----------------------------------------
	// cycle state machine
	// ----------------------------------------
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST)
			state <= ZS_IDLE;
		else
			state <= next;
	end

	always_comb begin
		next = state;
		// strobe up ends any cycle including an error
		if (bus_i.fcs_n) begin
			next = ZS_IDLE;
		end else begin
			case (state)
				ZS_IDLE:     if (cyc_i && hit) next = ZS_MATCH;
				ZS_MATCH:    if (doe_q) next = ZS_DATA;
				// writes hold here until a data strobe shows up
				ZS_DATA:     if (read_i || !(&ds_n_q)) next = ZS_REQ;
				ZS_REQ:      next = ZS_WAIT_ACK;
				ZS_WAIT_ACK: if (sel_rsp.ack) next = ZS_DTACK;
				ZS_DTACK:    if (tmo_hit) next = ZS_ERR;
				ZS_ERR:      next = ZS_ERR;
				default:     next = ZS_IDLE;
			endcase
		end
	end

	// ----------------------------------------
	// target request
	// ----------------------------------------
	// payload built on the way into ZS_REQ
	// stb high for the one clk spent in ZS_REQ
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			req_q <= '0;
		end else begin
			req_q.stb <= 1'b0;
			if (state == ZS_DATA && next == ZS_REQ) begin
				req_q.stb   <= 1'b1;
				req_q.we    <= ~read_i;
				// reads always fetch the full word
				req_q.be    <= read_i ? 4'hF : ~ds_n_q;
				req_q.idx   <= cfg_hit_i ? card_idx_t'(addr_i.cfg.reg_ofs)
					: addr_i.card.word[CARD_IDX_W-1:0];
				req_q.wdata <= bus_i.wdata;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == ZS_WAIT_ACK && sel_rsp.ack)
			rdata_q <= sel_rsp.rdata;
	end

	// strobe only to the target that was hit, for the one clk in ZS_REQ
	always_comb begin
		cfg_req_o     = req_q;
		cfg_req_o.stb = req_q.stb & cfg_hit_i;
		ram_req_o     = req_q;
		ram_req_o.stb = req_q.stb & card_hit_i;
	end

	// ----------------------------------------
	// dtack timeout
	// ----------------------------------------
	// counts clks spent in ZS_DTACK
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST)
			tmo_cnt <= '0;
		else if (state == ZS_DTACK)
			tmo_cnt <= tmo_cnt + 1'b1;
		else
			tmo_cnt <= '0;
	end

	// last clk of the allowed window
	assign tmo_hit = (tmo_cnt == TMO_W'(`Z3_DTACK_TIMEOUT - 1));

	assign dtack_n_o = ~(state == ZS_DTACK);
	// card drives data only while acknowledging a read
	assign data_oe_o = (state == ZS_DTACK) & read_i;
	assign rdata_o   = rdata_q;

endmodule

`default_nettype wire

/* design/z3_defs.svh */
// compile-time constants only; base byte gives a 16 MB slot and the 1 KB memory aliases inside it
`ifndef Z3_DEFS_SVH
`define Z3_DEFS_SVH

// ----------------------------------------
// bus constants
// ----------------------------------------
// memory space codes the card answers to
`define Z3_FC_DATA          2'b01
`define Z3_FC_PROG          2'b10

// upper address half of configuration space
`define Z3_CFG_SPACE        16'hFF00

// ----------------------------------------
// configuration register map
// ----------------------------------------
// byte offsets inside configuration space
`define Z3_CFG_TYPE_HI_OFS  9'h000
`define Z3_CFG_TYPE_LO_OFS  9'h004
`define Z3_CFG_PROD_HI_OFS  9'h008
`define Z3_CFG_PROD_LO_OFS  9'h00C
`define Z3_CFG_BASE_OFS     9'h044
`define Z3_CFG_SHUTUP_OFS   9'h04C

// identification nibbles
// type high: zorro III board, link into memory list
`define Z3_CFG_TYPE_HI      4'hA
`define Z3_CFG_TYPE_LO      4'h0
`define Z3_CFG_PROD_HI      4'h7
`define Z3_CFG_PROD_LO      4'h1

// ----------------------------------------
// card memory and cycle limits
// ----------------------------------------
`define CARD_RAM_WORDS      256
// clk cycles the acknowledge may stay up
`define Z3_DTACK_TIMEOUT    48

`endif

/* design/z3_ram_card.sv */
// card top; tri-state and open-drain buffering of the bus pins is left to the pad level
`default_nettype none

module z3_ram_card
	import z3_bus_pkg::*;
	import card_pkg::*;
(
	input  logic        clk,
	input  logic        nIORST,
	input  z3_bus_in_t  bus_i,
	input  logic        cfgin_n_i,
	input  logic        sense_z3_i,
	output z3_bus_out_t bus_o,
	output logic        cfgout_n_o
);

	// decoder results
	z3_addr_u    addr;
	logic        cfg_hit;
	logic        card_hit;
	logic        read;
	logic        cyc;
	logic        slave_n;
	// autoconfig state
	logic [7:0]  base;
	logic        configured;
	logic        shutup;
	// target handshakes
	card_req_t   cfg_req;
	card_req_t   ram_req;
	card_rsp_t   cfg_rsp;
	card_rsp_t   ram_rsp;
	// bus side of the controller
	logic        dtack_n;
	logic [31:0] rdata;
	logic        data_oe;

	// ----------------------------------------
	// address phase
	// ----------------------------------------
	z3_addr_decode decode_i (
		.clk          (clk),
		.nIORST       (nIORST),
		.bus_i        (bus_i),
		.cfgin_n_i    (cfgin_n_i),
		.sense_z3_i   (sense_z3_i),
		.base_i       (base),
		.configured_i (configured),
		.shutup_i     (shutup),
		.addr_o       (addr),
		.cfg_hit_o    (cfg_hit),
		.card_hit_o   (card_hit),
		.read_o       (read),
		.cyc_o        (cyc),
		.slave_n_o    (slave_n)
	);

	// ----------------------------------------
	// targets
	// ----------------------------------------
	autocfg_regs autocfg_i (
		.clk          (clk),
		.nIORST       (nIORST),
		.req_i        (cfg_req),
		.cfgin_n_i    (cfgin_n_i),
		.sense_z3_i   (sense_z3_i),
		.rsp_o        (cfg_rsp),
		.base_o       (base),
		.configured_o (configured),
		.shutup_o     (shutup),
		.cfgout_n_o   (cfgout_n_o)
	);

	card_ram ram_i (
		.clk    (clk),
		.nIORST (nIORST),
		.req_i  (ram_req),
		.rsp_o  (ram_rsp)
	);

	// ----------------------------------------
	// data phase
	// ----------------------------------------
	z3_cycle_ctrl ctrl_i (
		.clk        (clk),
		.nIORST     (nIORST),
		.bus_i      (bus_i),
		.addr_i     (addr),
		.cfg_hit_i  (cfg_hit),
		.card_hit_i (card_hit),
		.read_i     (read),
		.cyc_i      (cyc),
		.cfg_rsp_i  (cfg_rsp),
		.ram_rsp_i  (ram_rsp),
		.cfg_req_o  (cfg_req),
		.ram_req_o  (ram_req),
		.dtack_n_o  (dtack_n),
		.rdata_o    (rdata),
		.data_oe_o  (data_oe)
	);

	assign bus_o = '{slave_n: slave_n, dtack_n: dtack_n, rdata: rdata, data_oe: data_oe};

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the Zorro III card testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_z3_ram_card \
	-f z3_ram_card.f \
	--Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Result: FAILED" sim.log; then
	echo "simulation reported failure, see sim.log"
	exit 1
fi
echo "simulation finished, see sim.log"

/* z3_ram_card.f */
+incdir+design
design/z3_bus_pkg.sv
design/card_pkg.sv
design/z3_addr_decode.sv
design/autocfg_regs.sv
design/card_ram.sv
design/z3_cycle_ctrl.sv
design/z3_ram_card.sv
bench/tb_z3_ram_card.sv
